// File: rtl/wasm_pkg.sv
package wasm_pkg;

  typedef logic [7:0] opcode_t;

  // Control flow
  localparam opcode_t OP_UNREACHABLE = 8'h00;
  localparam opcode_t OP_NOP         = 8'h01;
  localparam opcode_t OP_END         = 8'h0B;

  // Parametric
  localparam opcode_t OP_DROP        = 8'h1A;
  localparam opcode_t OP_SELECT      = 8'h1B;

  // Constants
  localparam opcode_t OP_I32_CONST   = 8'h41;
  localparam opcode_t OP_I64_CONST   = 8'h42;

  // Comparison
  localparam opcode_t OP_I32_EQZ     = 8'h45;
  localparam opcode_t OP_I32_EQ      = 8'h46;
  localparam opcode_t OP_I32_NE      = 8'h47;
  localparam opcode_t OP_I64_EQZ     = 8'h50;
  localparam opcode_t OP_I64_EQ      = 8'h51;
  localparam opcode_t OP_I64_NE      = 8'h52;

  // Numeric
  localparam opcode_t OP_I32_ADD     = 8'h6A;
  localparam opcode_t OP_I32_SUB     = 8'h6B;
  localparam opcode_t OP_I64_ADD     = 8'h7C;
  localparam opcode_t OP_I64_SUB     = 8'h7D;

  typedef enum logic [1:0] {
    VT_I32,
    VT_I64,
    VT_F32,
    VT_F64
  } val_type_t;

  typedef enum logic [3:0] {
    TRAP_NONE,
    TRAP_ENDED,
    TRAP_UNREACHABLE,
    TRAP_UNKNOWN_OPCODE,
    TRAP_TYPE_MISMATCH,
    TRAP_STACK_EMPTY,
    TRAP_STACK_FULL,
    TRAP_ROM_ERROR
  } trap_t;

endpackage

// File: rtl/cpu_pkg.sv
package cpu_pkg;

  import wasm_pkg::*;

  // Program memory
  localparam int PROG_ADDR_W = 6;
  localparam int PROG_BYTES  = 1 << PROG_ADDR_W;

  typedef logic [PROG_ADDR_W-1:0] prog_addr_t;
  typedef logic [7:0]             prog_byte_t;

  // Opcode byte plus the longest LEB128 immediate
  localparam int FETCH_BYTES   = 11;
  localparam int LEB_MAX_BYTES = FETCH_BYTES - 1;

  typedef logic [8*FETCH_BYTES-1:0] fetch_window_t;
  typedef logic [63:0]              value_t;
  typedef logic [3:0]               leb_len_t;

  // Value stack
  localparam int STACK_DEPTH_W = 4;
  localparam int STACK_DEPTH   = 1 << STACK_DEPTH_W;

  typedef logic [STACK_DEPTH_W:0] stack_ptr_t;

  typedef struct packed {
    val_type_t vtype;
    value_t    value;
  } stack_entry_t;

  typedef enum logic [2:0] {
    STK_NONE,
    STK_PUSH,
    STK_POP,
    STK_REPLACE,
    STK_POP_REPLACE,
    STK_POP2_REPLACE
  } stack_op_t;

  typedef struct packed {
    stack_op_t    op;
    stack_entry_t data;
  } stack_cmd_t;

  typedef struct packed {
    stack_entry_t tos;
    stack_entry_t nos;
    stack_entry_t third;
    stack_ptr_t   count;
  } stack_view_t;

  typedef enum logic [1:0] {
    S_IDLE,
    S_FETCH,
    S_WAIT,
    S_EXEC
  } exec_state_t;

  // APB side
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // Program bytes sit below the registers
  localparam apb_addr_t REG_CTRL      = 8'h40;
  localparam apb_addr_t REG_STATUS    = 8'h44;
  localparam apb_addr_t REG_RESULT_LO = 8'h48;
  localparam apb_addr_t REG_RESULT_HI = 8'h4C;

  typedef struct packed {
    logic         running;
    trap_t        trap;
    stack_entry_t result;
    logic         empty;
  } core_status_t;

endpackage

// File: rtl/prog_mem.sv
`timescale 1ns/100ps

module prog_mem import cpu_pkg::*; (
  input  logic          clk,
  input  logic          wr_en,
  input  prog_addr_t    wr_addr,
  input  prog_byte_t    wr_data,
  input  logic          fetch_req,
  input  prog_addr_t    fetch_addr,
  output logic          fetch_gnt,
  output fetch_window_t fetch_window,
  output logic          rom_error
);

  prog_byte_t    mem [PROG_BYTES];
  fetch_window_t window_next;

  // Host write owns the cycle, fetch retries on the next one
  assign fetch_gnt = fetch_req && !wr_en;

  // Bytes past the end read as zero
  always_comb begin
    window_next = '0;
    for (int i = 0; i < FETCH_BYTES; i++) begin
      if (int'(fetch_addr) + i < PROG_BYTES) begin
        window_next[8*i +: 8] = mem[fetch_addr + PROG_ADDR_W'(i)];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_gnt) begin
      fetch_window <= window_next;
      rom_error    <= int'(fetch_addr) + FETCH_BYTES > PROG_BYTES;
    end
  end

endmodule

// File: rtl/leb128_decoder.sv
`timescale 1ns/100ps

module leb128_decoder import cpu_pkg::*; (
  input  fetch_window_t window,
  output value_t        value,
  output leb_len_t      len
);

  prog_byte_t group_byte;
  logic       done;

  // Immediate starts at byte 1, byte 0 holds the opcode
  always_comb begin
    value      = '0;
    len        = leb_len_t'(LEB_MAX_BYTES);
    done       = 1'b0;
    group_byte = '0;
    for (int i = 0; i < LEB_MAX_BYTES; i++) begin
      if (!done) begin
        group_byte = window[8*(i+1) +: 8];
        value      = value | (value_t'(group_byte[6:0]) << (7*i));
        if (!group_byte[7]) begin
          done = 1'b1;
          len  = leb_len_t'(i + 1);
          // Sign bit of last group fills everything above it
          if (group_byte[6]) begin
            value = value | ({64{1'b1}} << (7*(i+1)));
          end
        end
      end
    end
  end

endmodule

// File: rtl/value_stack.sv
`timescale 1ns/100ps

module value_stack import cpu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        clear,
  input  stack_cmd_t  cmd,
  output stack_view_t view
);

  stack_entry_t             mem [STACK_DEPTH];
  stack_ptr_t               count;
  logic [STACK_DEPTH_W-1:0] idx1;
  logic [STACK_DEPTH_W-1:0] idx2;
  logic [STACK_DEPTH_W-1:0] idx3;

  // Slots of the three top entries, wrap when shallow
  assign idx1 = count[STACK_DEPTH_W-1:0] - 1'b1;
  assign idx2 = count[STACK_DEPTH_W-1:0] - 2'd2;
  assign idx3 = count[STACK_DEPTH_W-1:0] - 2'd3;

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      count <= '0;
    end else begin
      case (cmd.op)
        STK_PUSH:                  count <= count + 1'b1;
        STK_POP, STK_POP_REPLACE:  count <= count - 1'b1;
        STK_POP2_REPLACE:          count <= count - 2'd2;
        default: ;
      endcase
    end
  end

  // Result lands where the deepest operand was
  always_ff @(posedge clk) begin
    case (cmd.op)
      STK_PUSH:         mem[count[STACK_DEPTH_W-1:0]] <= cmd.data;
      STK_REPLACE:      mem[idx1] <= cmd.data;
      STK_POP_REPLACE:  mem[idx2] <= cmd.data;
      STK_POP2_REPLACE: mem[idx3] <= cmd.data;
      default: ;
    endcase
  end

  assign view.tos   = mem[idx1];
  assign view.nos   = mem[idx2];
  assign view.third = mem[idx3];
  assign view.count = count;

endmodule

// File: rtl/exec_core.sv
`timescale 1ns/100ps

module exec_core import wasm_pkg::*; import cpu_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          start,
  output logic          fetch_req,
  output prog_addr_t    fetch_addr,
  input  logic          fetch_gnt,
  input  fetch_window_t fetch_window,
  input  logic          rom_error,
  input  value_t        imm,
  input  leb_len_t      imm_len,
  output stack_cmd_t    stack_cmd,
  output logic          stack_clear,
  input  stack_view_t   view,
  output core_status_t  status
);

  exec_state_t  state;
  prog_addr_t   pc;
  logic         running;
  trap_t        trap;

  opcode_t      opcode;
  logic         wide;
  val_type_t    want;
  value_t       ua;
  value_t       ub;
  value_t       sum;
  value_t       diff;
  trap_t        exec_trap;
  stack_op_t    cmd_op;
  stack_entry_t res;
  prog_addr_t   pc_step;

  assign opcode      = fetch_window[7:0];
  assign fetch_req   = state == S_FETCH;
  assign fetch_addr  = pc;
  assign stack_clear = start;

  // a is the second entry, b the top; i32 keeps only the low word
  always_comb begin
    wide = opcode inside {OP_I64_CONST, OP_I64_EQZ, OP_I64_EQ, OP_I64_NE,
                          OP_I64_ADD, OP_I64_SUB};
    want = wide ? VT_I64 : VT_I32;
    ua   = wide ? view.nos.value : {32'd0, view.nos.value[31:0]};
    ub   = wide ? view.tos.value : {32'd0, view.tos.value[31:0]};
    sum  = ua + ub;
    diff = ua - ub;
  end

  // Decode and checks, only acted on in S_EXEC
  always_comb begin
    exec_trap = TRAP_NONE;
    cmd_op    = STK_NONE;
    res.vtype = VT_I32;
    res.value = '0;
    pc_step   = prog_addr_t'(1);
    if (rom_error) begin
      exec_trap = TRAP_ROM_ERROR;
    end else begin
      case (opcode)
        OP_UNREACHABLE: exec_trap = TRAP_UNREACHABLE;
        OP_NOP: ;
        // No call stack, so end always halts
        OP_END: exec_trap = TRAP_ENDED;
        OP_DROP: begin
          if (view.count == '0)
            exec_trap = TRAP_STACK_EMPTY;
          else
            cmd_op = STK_POP;
        end
        OP_SELECT: begin
          res = (view.tos.value[31:0] != '0) ? view.third : view.nos;
          if (view.count < 3)
            exec_trap = TRAP_STACK_EMPTY;
          else if (view.tos.vtype != VT_I32 || view.nos.vtype != view.third.vtype)
            exec_trap = TRAP_TYPE_MISMATCH;
          else
            cmd_op = STK_POP2_REPLACE;
        end
        OP_I32_CONST, OP_I64_CONST: begin
          pc_step   = PROG_ADDR_W'(imm_len) + 1'b1;
          res.vtype = want;
          res.value = wide ? imm : {32'd0, imm[31:0]};
          if (view.count == STACK_DEPTH)
            exec_trap = TRAP_STACK_FULL;
          else
            cmd_op = STK_PUSH;
        end
        OP_I32_EQZ, OP_I64_EQZ: begin
          res.value = {63'd0, ub == '0};
          if (view.count == '0)
            exec_trap = TRAP_STACK_EMPTY;
          else if (view.tos.vtype != want)
            exec_trap = TRAP_TYPE_MISMATCH;
          else
            cmd_op = STK_REPLACE;
        end
        OP_I32_EQ, OP_I32_NE, OP_I64_EQ, OP_I64_NE,
        OP_I32_ADD, OP_I32_SUB, OP_I64_ADD, OP_I64_SUB: begin
          case (opcode)
            OP_I32_EQ, OP_I64_EQ: res.value = {63'd0, ua == ub};
            OP_I32_NE, OP_I64_NE: res.value = {63'd0, ua != ub};
            OP_I32_ADD, OP_I64_ADD: begin
              res.vtype = want;
              res.value = wide ? sum : {32'd0, sum[31:0]};
            end
            default: begin
              res.vtype = want;
              res.value = wide ? diff : {32'd0, diff[31:0]};
            end
          endcase
          if (view.count < 2)
            exec_trap = TRAP_STACK_EMPTY;
          else if (view.tos.vtype != want || view.nos.vtype != want)
            exec_trap = TRAP_TYPE_MISMATCH;
          else
            cmd_op = STK_POP_REPLACE;
        end
        default: exec_trap = TRAP_UNKNOWN_OPCODE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= S_IDLE;
      pc      <= '0;
      running <= 1'b0;
      trap    <= TRAP_NONE;
    end else if (start) begin
      state   <= S_FETCH;
      pc      <= '0;
      running <= 1'b1;
      trap    <= TRAP_NONE;
    end else begin
      case (state)
        S_FETCH: if (fetch_gnt) state <= S_WAIT;
        S_WAIT:  state <= S_EXEC;
        S_EXEC: begin
          if (exec_trap != TRAP_NONE) begin
            trap    <= exec_trap;
            running <= 1'b0;
            state   <= S_IDLE;
          end else begin
            pc    <= pc + pc_step;
            state <= S_FETCH;
          end
        end
        default: ;
      endcase
    end
  end

  // Stack update lands on the edge into the next fetch
  assign stack_cmd.op   = (state == S_EXEC) ? cmd_op : STK_NONE;
  assign stack_cmd.data = res;

  assign status.running = running;
  assign status.trap    = trap;
  assign status.result  = view.tos;
  assign status.empty   = view.count == '0;

endmodule

// File: rtl/apb_host_port.sv
`timescale 1ns/100ps

module apb_host_port import cpu_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         psel,
  input  logic         penable,
  input  logic         pwrite,
  input  apb_addr_t    paddr,
  input  apb_data_t    pwdata,
  output apb_data_t    prdata,
  output logic         pready,
  output logic         pslverr,
  output logic         mem_wr_en,
  output prog_addr_t   mem_wr_addr,
  output prog_byte_t   mem_wr_data,
  output logic         start,
  input  core_status_t status
);

  logic access;
  logic is_prog;
  logic mapped;

  assign access  = psel && penable;
  assign is_prog = paddr < PROG_BYTES;
  assign mapped  = is_prog || paddr inside {REG_CTRL, REG_STATUS, REG_RESULT_LO, REG_RESULT_HI};

  // Zero wait states
  assign pready  = 1'b1;
  assign pslverr = access && !mapped;

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wr_en <= 1'b0;
      start     <= 1'b0;
    end else begin
      mem_wr_en <= access && pwrite && is_prog;
      start     <= access && pwrite && paddr == REG_CTRL && pwdata[0];
    end
  end

  always_ff @(posedge clk) begin
    if (access && pwrite) begin
      mem_wr_addr <= paddr[PROG_ADDR_W-1:0];
      mem_wr_data <= pwdata[7:0];
    end
  end

  // Program bytes are write only and read as zero
  always_comb begin
    case (paddr)
      REG_CTRL:      prdata = {31'd0, status.running};
      REG_STATUS:    prdata = {24'd0, status.result.vtype, status.empty,
                               status.trap, status.running};
      REG_RESULT_LO: prdata = status.result.value[31:0];
      REG_RESULT_HI: prdata = status.result.value[63:32];
      default:       prdata = '0;
    endcase
  end

endmodule

// File: rtl/wasm_cpu_top.sv
`timescale 1ns/100ps

module wasm_cpu_top import cpu_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr
);

  logic          mem_wr_en;
  prog_addr_t    mem_wr_addr;
  prog_byte_t    mem_wr_data;
  logic          start;
  core_status_t  status;
  logic          fetch_req;
  logic          fetch_gnt;
  prog_addr_t    fetch_addr;
  fetch_window_t fetch_window;
  logic          rom_error;
  value_t        imm;
  leb_len_t      imm_len;
  stack_cmd_t    stack_cmd;
  logic          stack_clear;
  stack_view_t   view;

  apb_host_port i_apb_host_port (
    .clk(clk), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .mem_wr_en(mem_wr_en), .mem_wr_addr(mem_wr_addr), .mem_wr_data(mem_wr_data),
    .start(start), .status(status)
  );

  prog_mem i_prog_mem (
    .clk(clk),
    .wr_en(mem_wr_en), .wr_addr(mem_wr_addr), .wr_data(mem_wr_data),
    .fetch_req(fetch_req), .fetch_addr(fetch_addr), .fetch_gnt(fetch_gnt),
    .fetch_window(fetch_window), .rom_error(rom_error)
  );

  leb128_decoder i_leb128_decoder (
    .window(fetch_window), .value(imm), .len(imm_len)
  );

  exec_core i_exec_core (
    .clk(clk), .reset(reset), .start(start),
    .fetch_req(fetch_req), .fetch_addr(fetch_addr), .fetch_gnt(fetch_gnt),
    .fetch_window(fetch_window), .rom_error(rom_error),
    .imm(imm), .imm_len(imm_len),
    .stack_cmd(stack_cmd), .stack_clear(stack_clear), .view(view),
    .status(status)
  );

  value_stack i_value_stack (
    .clk(clk), .reset(reset), .clear(stack_clear), .cmd(stack_cmd), .view(view)
  );

endmodule

// File: dv/wasm_cpu_tb.sv
`timescale 1ns/100ps

module wasm_cpu_tb import wasm_pkg::*; import cpu_pkg::*; ();

  localparam int NUM_TESTS       = 40;
  localparam int WATCHDOG_CYCLES = 200 * NUM_TESTS;

  localparam opcode_t ARITH_OPS [4] = '{OP_I32_ADD, OP_I32_SUB, OP_I64_ADD, OP_I64_SUB};
  localparam opcode_t CMP_OPS [4]   = '{OP_I32_EQ, OP_I32_NE, OP_I64_EQ, OP_I64_NE};

  typedef struct packed {
    trap_t        trap;
    stack_entry_t res;
  } expect_t;

  logic      clk = 1'b0;
  logic      reset;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;

  logic [15:0] lfsr = 16'd23313;
  prog_byte_t  prog_q [$];
  int          num_checks = 0;
  int          num_errors = 0;

  wasm_cpu_top i_wasm_cpu_top (
    .clk(clk), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  always #2 clk = ~clk;

  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic value_t rand_bits(int n);
    value_t r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r    = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  // Random shift gives short, long, positive and negative encodings
  function automatic value_t rand_value(logic wide);
    value_t v;
    v = rand_bits(64);
    v = value_t'($signed(v) >>> rand_bits(6));
    return wide ? v : {32'd0, v[31:0]};
  endfunction

  function automatic stack_entry_t make_entry(val_type_t t, value_t v);
    stack_entry_t e;
    e.vtype = t;
    e.value = v;
    return e;
  endfunction

  function automatic prog_byte_t fill_byte(prog_addr_t addr);
    return {addr, 2'b10} ^ 8'h3C;
  endfunction

  // t0 is the top of stack, t1 the second entry, t2 the third
  function automatic expect_t ref_op(opcode_t op, int depth, stack_entry_t t0,
                                     stack_entry_t t1, stack_entry_t t2, value_t imm);
    expect_t     e;
    logic        is64;
    val_type_t   want;
    value_t      x;
    value_t      y;
    logic [31:0] lo;
    e.trap = TRAP_NONE;
    e.res  = make_entry(VT_I32, '0);
    is64   = op inside {OP_I64_CONST, OP_I64_EQZ, OP_I64_EQ, OP_I64_NE,
                        OP_I64_ADD, OP_I64_SUB};
    want   = is64 ? VT_I64 : VT_I32;
    x      = is64 ? t1.value : {32'd0, t1.value[31:0]};
    y      = is64 ? t0.value : {32'd0, t0.value[31:0]};
    case (op)
      OP_UNREACHABLE: e.trap = TRAP_UNREACHABLE;
      OP_I32_CONST, OP_I64_CONST: begin
        if (depth >= STACK_DEPTH)
          e.trap = TRAP_STACK_FULL;
        else
          e.res = make_entry(want, is64 ? imm : {32'd0, imm[31:0]});
      end
      OP_DROP: begin
        if (depth < 1)
          e.trap = TRAP_STACK_EMPTY;
        else
          e.res = t1;
      end
      OP_SELECT: begin
        if (depth < 3)
          e.trap = TRAP_STACK_EMPTY;
        else if (t0.vtype != VT_I32 || t1.vtype != t2.vtype)
          e.trap = TRAP_TYPE_MISMATCH;
        else
          e.res = (t0.value[31:0] != 32'd0) ? t2 : t1;
      end
      OP_I32_EQZ, OP_I64_EQZ: begin
        if (depth < 1)
          e.trap = TRAP_STACK_EMPTY;
        else if (t0.vtype != want)
          e.trap = TRAP_TYPE_MISMATCH;
        else
          e.res = make_entry(VT_I32, value_t'(y == '0));
      end
      OP_I32_EQ, OP_I32_NE, OP_I64_EQ, OP_I64_NE,
      OP_I32_ADD, OP_I32_SUB, OP_I64_ADD, OP_I64_SUB: begin
        if (depth < 2) begin
          e.trap = TRAP_STACK_EMPTY;
        end else if (t0.vtype != want || t1.vtype != want) begin
          e.trap = TRAP_TYPE_MISMATCH;
        end else begin
          case (op)
            OP_I32_EQ, OP_I64_EQ: e.res = make_entry(VT_I32, value_t'(x == y));
            OP_I32_NE, OP_I64_NE: e.res = make_entry(VT_I32, value_t'(x != y));
            OP_I32_ADD: begin
              lo    = x[31:0] + y[31:0];
              e.res = make_entry(VT_I32, {32'd0, lo});
            end
            OP_I32_SUB: begin
              lo    = x[31:0] - y[31:0];
              e.res = make_entry(VT_I32, {32'd0, lo});
            end
            OP_I64_ADD: e.res = make_entry(VT_I64, x + y);
            default:    e.res = make_entry(VT_I64, x - y);
          endcase
        end
      end
      default: e.trap = TRAP_UNKNOWN_OPCODE;
    endcase
    return e;
  endfunction

  task automatic check(string name, value_t exp, value_t act);
    num_checks++;
    if (exp !== act) begin
      num_errors++;
      $display("Error: %s expected 0x%0h, actual 0x%0h", name, exp, act);
    end
  endtask

  task automatic apb_write(apb_addr_t addr, apb_data_t data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // Sampled on the falling edge after the access phase
  task automatic apb_read(apb_addr_t addr, output apb_data_t data, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    data    = prdata;
    err     = pslverr;
    check("apb pready", 64'd1, value_t'(pready));
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // Signed LEB128 with i32 immediates sign extended from bit 31
  task automatic emit_const(stack_entry_t e);
    value_t     v;
    prog_byte_t b;
    logic       done;
    prog_q.push_back(e.vtype == VT_I64 ? OP_I64_CONST : OP_I32_CONST);
    v    = (e.vtype == VT_I64) ? e.value : {{32{e.value[31]}}, e.value[31:0]};
    done = 1'b0;
    while (!done) begin
      b    = {1'b0, v[6:0]};
      v    = value_t'($signed(v) >>> 7);
      done = (v == '0 && !b[6]) || (v == '1 && b[6]);
      if (!done)
        b[7] = 1'b1;
      prog_q.push_back(b);
    end
  endtask

  task automatic load_and_start();
    foreach (prog_q[i])
      apb_write(apb_addr_t'(i), {24'd0, prog_q[i]});
    apb_write(REG_CTRL, 32'd1);
    prog_q.delete();
  endtask

  task automatic wait_done(output apb_data_t status, output value_t result);
    apb_data_t lo;
    apb_data_t hi;
    logic      err;
    do begin
      apb_read(REG_STATUS, status, err);
    end while (status[0]);
    apb_read(REG_RESULT_LO, lo, err);
    apb_read(REG_RESULT_HI, hi, err);
    result = {hi, lo};
  endtask

  task automatic op_test(string name, opcode_t op, int depth, stack_entry_t t0,
                         stack_entry_t t1, stack_entry_t t2, value_t imm, bit host_busy);
    expect_t   e;
    apb_data_t status;
    value_t    result;
    trap_t     exp_trap;
    logic      exp_empty;
    e = ref_op(op, depth, t0, t1, t2, imm);
    for (int k = depth - 1; k >= 0; k--) begin
      case (k)
        0: emit_const(t0);
        1: emit_const(t1);
        2: emit_const(t2);
        default: emit_const(make_entry(VT_I32, value_t'(k)));
      endcase
    end
    if (op == OP_I32_CONST || op == OP_I64_CONST)
      emit_const(make_entry(op == OP_I64_CONST ? VT_I64 : VT_I32, imm));
    else
      prog_q.push_back(op);
    prog_q.push_back(OP_END);
    load_and_start();
    // Writes land well past the program
    if (host_busy) begin
      // One idle cycle puts a write on the second fetch cycle
      @(negedge clk);
      for (int addr = 40; addr < 48; addr++)
        apb_write(apb_addr_t'(addr), {24'd0, fill_byte(prog_addr_t'(addr))});
    end
    wait_done(status, result);
    exp_trap  = (e.trap == TRAP_NONE) ? TRAP_ENDED : e.trap;
    exp_empty = (e.trap == TRAP_NONE) ? (op == OP_DROP && depth == 1) : (depth == 0);
    check({name, " trap"}, value_t'(exp_trap), value_t'(status[4:1]));
    check({name, " empty"}, value_t'(exp_empty), value_t'(status[5]));
    if (e.trap == TRAP_NONE) begin
      check({name, " type"}, value_t'(e.res.vtype), value_t'(status[7:6]));
      check({name, " value"}, e.res.value, result);
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    stack_entry_t z;
    opcode_t      op;
    logic         wide;
    val_type_t    vt;
    value_t       a;
    value_t       b;
    value_t       c;
    apb_data_t    rd;
    logic         err;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    reset   = 1'b1;
    z       = make_entry(VT_I32, '0);
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < 6; i++) begin
      wide = i[0];
      op_test($sformatf("const_%0d", i), wide ? OP_I64_CONST : OP_I32_CONST, 0, z, z, z,
              rand_value(wide), 1'b0);
    end
    op_test("const_i64_min", OP_I64_CONST, 0, z, z, z, 64'h8000_0000_0000_0000, 1'b0);
    op_test("const_i32_neg1", OP_I32_CONST, 0, z, z, z, 64'hFFFF_FFFF, 1'b0);

    for (int i = 0; i < 8; i++) begin
      op   = ARITH_OPS[i % 4];
      wide = op inside {OP_I64_ADD, OP_I64_SUB};
      vt   = wide ? VT_I64 : VT_I32;
      op_test($sformatf("arith_%0d", i), op, 2, make_entry(vt, rand_value(wide)),
              make_entry(vt, rand_value(wide)), z, '0, 1'b0);
    end
    op_test("i32_add_wrap", OP_I32_ADD, 2, make_entry(VT_I32, 64'h20),
            make_entry(VT_I32, 64'hFFFF_FFF0), z, '0, 1'b0);

    // Unequal operands differ in the low byte
    for (int i = 0; i < 8; i++) begin
      op   = CMP_OPS[i / 2];
      wide = op inside {OP_I64_EQ, OP_I64_NE};
      vt   = wide ? VT_I64 : VT_I32;
      a    = rand_value(wide);
      b    = i[0] ? a : (a ^ (rand_bits(8) | 64'd1));
      op_test($sformatf("cmp_%0d", i), op, 2, make_entry(vt, b), make_entry(vt, a), z,
              '0, 1'b0);
    end
    for (int i = 0; i < 4; i++) begin
      wide = i[1];
      vt   = wide ? VT_I64 : VT_I32;
      a    = i[0] ? '0 : (rand_value(wide) | 64'd1);
      op_test($sformatf("eqz_%0d", i), wide ? OP_I64_EQZ : OP_I32_EQZ, 1,
              make_entry(vt, a), z, z, '0, 1'b0);
    end

    for (int i = 0; i < 4; i++) begin
      wide = i[1];
      vt   = wide ? VT_I64 : VT_I32;
      c    = i[0] ? rand_bits(31) + 64'd1 : '0;
      op_test($sformatf("select_%0d", i), OP_SELECT, 3, make_entry(VT_I32, c),
              make_entry(vt, rand_value(wide)), make_entry(vt, rand_value(wide)), '0, 1'b0);
    end
    op_test("drop", OP_DROP, 2, make_entry(VT_I32, rand_value(1'b0)),
            make_entry(VT_I64, rand_value(1'b1)), z, '0, 1'b0);

    op_test("trap_type", OP_I32_ADD, 2, make_entry(VT_I64, 64'd7),
            make_entry(VT_I32, 64'd5), z, '0, 1'b0);
    op_test("trap_empty", OP_DROP, 0, z, z, z, '0, 1'b0);
    op_test("trap_unreachable", OP_UNREACHABLE, 0, z, z, z, '0, 1'b0);
    op_test("trap_unknown", 8'hFF, 0, z, z, z, '0, 1'b0);
    op_test("trap_full", OP_I32_CONST, STACK_DEPTH, make_entry(VT_I32, 64'd1),
            make_entry(VT_I32, 64'd2), make_entry(VT_I32, 64'd3), 64'd9, 1'b0);

    op_test("host_stall", OP_I64_ADD, 2, make_entry(VT_I64, rand_value(1'b1)),
            make_entry(VT_I64, rand_value(1'b1)), z, '0, 1'b1);

    apb_read(8'h50, rd, err);
    check("unmapped pslverr", 64'd1, value_t'(err));
    apb_read(REG_CTRL, rd, err);
    check("mapped pslverr", 64'd0, value_t'(err));
    check("ctrl running", 64'd0, value_t'(rd));

    $display("Checks: %0d, errors: %0d", num_checks, num_errors);
    if (num_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: sim.f
rtl/wasm_pkg.sv
rtl/cpu_pkg.sv
rtl/prog_mem.sv
rtl/leb128_decoder.sv
rtl/value_stack.sv
rtl/exec_core.sv
rtl/apb_host_port.sv
rtl/wasm_cpu_top.sv
dv/wasm_cpu_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --timing -Wno-fatal
TOP       = wasm_cpu_tb
FILELIST  = sim.f
OBJDIR    = obj_dir
PASS_MSG  = Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
